//--- common/vga_pkg.sv
package vga_pkg;

  typedef logic [11:0] coord_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // 2 x 12 bit counters plus 4 flags, 28 bits
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
  } vga_timing_t;

  localparam rgb_t COLOR_BLACK = 12'h000;

  // 1024x768 at 60 Hz, 65 MHz pixel clock
  localparam int XGA_H_ACTIVE = 1024;
  localparam int XGA_H_FP     = 24;
  localparam int XGA_H_SYNC   = 136;
  localparam int XGA_H_BP     = 160;

  localparam int XGA_V_ACTIVE = 768;
  localparam int XGA_V_FP     = 3;
  localparam int XGA_V_SYNC   = 6;
  localparam int XGA_V_BP     = 29;

endpackage

//--- common/game_pkg.sv
package game_pkg;

  typedef struct packed {
    vga_pkg::coord_t x;
    vga_pkg::coord_t y;
  } pos_t;

  typedef logic [3:0] hp_t;

  // playfield and overlay colours
  localparam vga_pkg::rgb_t COLOR_BG       = 12'h213;
  localparam vga_pkg::rgb_t COLOR_BORDER   = 12'hccc;
  localparam vga_pkg::rgb_t COLOR_ARENA    = 12'h041;
  localparam vga_pkg::rgb_t COLOR_OBSTACLE = 12'hf80;
  localparam vga_pkg::rgb_t COLOR_HP       = 12'hf00;

  // obstacle rectangle size in pixels
  localparam int OBSTACLE_W = 8;
  localparam int OBSTACLE_H = 8;

  // health bar width per point
  localparam int HP_BAR_UNIT = 2;

  // arena on the XGA screen, lines are inclusive
  localparam int DEF_ARENA_TOP    = 317;
  localparam int DEF_ARENA_BOTTOM = 617;
  localparam int DEF_ARENA_LEFT   = 361;
  localparam int DEF_ARENA_RIGHT  = 661;
  localparam int DEF_BORDER       = 7;

  // starting health, must fit in hp_t
  localparam int DEF_HP_MAX = 10;

endpackage

//--- common/vga_if.sv
`timescale 1ns/1ps

// one pixel per pclk, no handshake
interface vga_if;

  vga_pkg::vga_timing_t timing;
  vga_pkg::rgb_t        rgb;

  // driving stage
  modport src (
    output timing,
    output rgb
  );

  // reading stage
  modport snk (
    input timing,
    input rgb
  );

endinterface

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = vga_pkg::XGA_H_ACTIVE,
  parameter int H_FP     = vga_pkg::XGA_H_FP,
  parameter int H_SYNC   = vga_pkg::XGA_H_SYNC,
  parameter int H_BP     = vga_pkg::XGA_H_BP,
  parameter int V_ACTIVE = vga_pkg::XGA_V_ACTIVE,
  parameter int V_FP     = vga_pkg::XGA_V_FP,
  parameter int V_SYNC   = vga_pkg::XGA_V_SYNC,
  parameter int V_BP     = vga_pkg::XGA_V_BP
) (
  input  logic pclk,
  input  logic rst_n,
  vga_if.src   out
);

  localparam vga_pkg::coord_t H_LAST     = vga_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam vga_pkg::coord_t V_LAST     = vga_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
  localparam vga_pkg::coord_t H_BLANK    = vga_pkg::coord_t'(H_ACTIVE);
  localparam vga_pkg::coord_t V_BLANK    = vga_pkg::coord_t'(V_ACTIVE);
  localparam vga_pkg::coord_t HS_START   = vga_pkg::coord_t'(H_ACTIVE + H_FP);
  localparam vga_pkg::coord_t HS_END     = vga_pkg::coord_t'(H_ACTIVE + H_FP + H_SYNC);
  localparam vga_pkg::coord_t VS_START   = vga_pkg::coord_t'(V_ACTIVE + V_FP);
  localparam vga_pkg::coord_t VS_END     = vga_pkg::coord_t'(V_ACTIVE + V_FP + V_SYNC);

  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_LAST) begin
      hcount <= '0;
      vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // sync and blank decoded straight from the counters
  assign out.timing.hcount = hcount;
  assign out.timing.vcount = vcount;
  assign out.timing.hsync  = (hcount >= HS_START) && (hcount < HS_END);
  assign out.timing.vsync  = (vcount >= VS_START) && (vcount < VS_END);
  assign out.timing.hblnk  = (hcount >= H_BLANK);
  assign out.timing.vblnk  = (vcount >= V_BLANK);

  // no picture at the source
  assign out.rgb = vga_pkg::COLOR_BLACK;

endmodule

//--- hdl/signal_delay.sv
`timescale 1ns/1ps

module signal_delay #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic pclk,
  input  logic rst_n,
  input  T     din,
  output T     dout
);

  T stage [DEPTH];

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

//--- arena/arena_draw.sv
`timescale 1ns/1ps

module arena_draw #(
  parameter int ARENA_TOP    = game_pkg::DEF_ARENA_TOP,
  parameter int ARENA_BOTTOM = game_pkg::DEF_ARENA_BOTTOM,
  parameter int ARENA_LEFT   = game_pkg::DEF_ARENA_LEFT,
  parameter int ARENA_RIGHT  = game_pkg::DEF_ARENA_RIGHT,
  parameter int BORDER       = game_pkg::DEF_BORDER
) (
  input  logic pclk,
  input  logic rst_n,
  input  logic game_button,
  input  logic menu_button,
  input  logic game_over,
  vga_if.snk   in,
  vga_if.src   out,
  output logic play_on
);

  int hc;
  int vc;
  logic in_arena;
  logic in_ring;
  vga_pkg::rgb_t pix;
  vga_pkg::rgb_t rgb_q;

  always_comb begin
    hc = int'(in.timing.hcount);
    vc = int'(in.timing.vcount);
    in_arena = (hc >= ARENA_LEFT) && (hc <= ARENA_RIGHT) &&
               (vc >= ARENA_TOP) && (vc <= ARENA_BOTTOM);
    in_ring  = (hc >= ARENA_LEFT - BORDER) && (hc <= ARENA_RIGHT + BORDER) &&
               (vc >= ARENA_TOP - BORDER) && (vc <= ARENA_BOTTOM + BORDER);
    if (in.timing.hblnk || in.timing.vblnk)
      pix = vga_pkg::COLOR_BLACK;
    else if (in_arena)
      pix = game_pkg::COLOR_ARENA;
    else if (in_ring)
      pix = game_pkg::COLOR_BORDER;
    else
      pix = game_pkg::COLOR_BG;
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      rgb_q <= '0;
    end else begin
      rgb_q <= pix;
    end
  end

  // menu and game over take priority over start
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      play_on <= 1'b0;
    end else if (menu_button || game_over) begin
      play_on <= 1'b0;
    end else if (game_button) begin
      play_on <= 1'b1;
    end
  end

  signal_delay #(.T(vga_pkg::vga_timing_t), .DEPTH(1)) timing_delay (
    .pclk  (pclk),
    .rst_n (rst_n),
    .din   (in.timing),
    .dout  (out.timing)
  );

  assign out.rgb = rgb_q;

endmodule

//--- arena/obstacle_layer.sv
`timescale 1ns/1ps

module obstacle_layer #(
  parameter int ARENA_TOP   = game_pkg::DEF_ARENA_TOP,
  parameter int ARENA_LEFT  = game_pkg::DEF_ARENA_LEFT,
  parameter int ARENA_RIGHT = game_pkg::DEF_ARENA_RIGHT,
  parameter int BORDER      = game_pkg::DEF_BORDER
) (
  input  logic            pclk,
  input  logic            rst_n,
  input  logic            play_on,
  vga_if.snk              in,
  vga_if.src              out,
  output game_pkg::pos_t  obstacle
);

  localparam vga_pkg::coord_t HOME_X = vga_pkg::coord_t'(ARENA_LEFT + BORDER);
  localparam vga_pkg::coord_t HOME_Y = vga_pkg::coord_t'(ARENA_TOP + BORDER);

  logic frame_start;
  logic move_left;
  logic in_rect;
  int hc;
  int vc;
  int ox;
  int oy;
  vga_pkg::rgb_t rgb_q;

  assign frame_start = (in.timing.hcount == '0) && (in.timing.vcount == '0);

  // one step per frame, bounce off the inner walls
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      obstacle.x <= HOME_X;
      obstacle.y <= HOME_Y;
      move_left  <= 1'b0;
    end else if (frame_start) begin
      if (!play_on) begin
        obstacle.x <= HOME_X;
        obstacle.y <= HOME_Y;
        move_left  <= 1'b0;
      end else if (move_left) begin
        obstacle.x <= obstacle.x - 1'b1;
        if (int'(obstacle.x) - 1 <= ARENA_LEFT)
          move_left <= 1'b0;
      end else begin
        obstacle.x <= obstacle.x + 1'b1;
        if (int'(obstacle.x) + game_pkg::OBSTACLE_W >= ARENA_RIGHT)
          move_left <= 1'b1;
      end
    end
  end

  always_comb begin
    hc = int'(in.timing.hcount);
    vc = int'(in.timing.vcount);
    ox = int'(obstacle.x);
    oy = int'(obstacle.y);
    in_rect = (hc >= ox) && (hc < ox + game_pkg::OBSTACLE_W) &&
              (vc >= oy) && (vc < oy + game_pkg::OBSTACLE_H) &&
              !in.timing.hblnk && !in.timing.vblnk;
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      rgb_q <= '0;
    end else begin
      rgb_q <= in_rect ? game_pkg::COLOR_OBSTACLE : in.rgb;
    end
  end

  signal_delay #(.T(vga_pkg::vga_timing_t), .DEPTH(1)) timing_delay (
    .pclk  (pclk),
    .rst_n (rst_n),
    .din   (in.timing),
    .dout  (out.timing)
  );

  assign out.rgb = rgb_q;

endmodule

//--- hdl/collision_detector.sv
`timescale 1ns/1ps

module collision_detector (
  input  logic           pclk,
  input  logic           rst_n,
  input  game_pkg::pos_t cursor,
  input  game_pkg::pos_t obstacle,
  input  logic           frame_start,
  output logic           damage
);

  game_pkg::pos_t cursor_q;
  game_pkg::pos_t obstacle_q;
  logic           sample_q;
  logic           hit;

  signal_delay #(.T(game_pkg::pos_t), .DEPTH(1)) cursor_delay (
    .pclk  (pclk),
    .rst_n (rst_n),
    .din   (cursor),
    .dout  (cursor_q)
  );

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      obstacle_q <= '0;
      sample_q   <= 1'b0;
    end else begin
      obstacle_q <= obstacle;
      sample_q   <= frame_start;
    end
  end

  // rectangle edges count as a hit
  assign hit = (int'(cursor_q.x) >= int'(obstacle_q.x)) &&
               (int'(cursor_q.x) <= int'(obstacle_q.x) + game_pkg::OBSTACLE_W - 1) &&
               (int'(cursor_q.y) >= int'(obstacle_q.y)) &&
               (int'(cursor_q.y) <= int'(obstacle_q.y) + game_pkg::OBSTACLE_H - 1);

  assign damage = sample_q && hit;

endmodule

//--- hdl/hp_overlay.sv
`timescale 1ns/1ps

module hp_overlay #(
  parameter int ARENA_TOP  = game_pkg::DEF_ARENA_TOP,
  parameter int ARENA_LEFT = game_pkg::DEF_ARENA_LEFT,
  parameter int BORDER     = game_pkg::DEF_BORDER,
  parameter int HP_MAX     = game_pkg::DEF_HP_MAX
) (
  input  logic          pclk,
  input  logic          rst_n,
  input  logic          play_on,
  input  logic          damage,
  vga_if.snk            in,
  vga_if.src            out,
  output game_pkg::hp_t hp,
  output logic          game_over
);

  localparam game_pkg::hp_t HP_FULL = game_pkg::hp_t'(HP_MAX);

  // four rows just above the top border
  localparam int BAR_TOP    = ARENA_TOP - BORDER - 4;
  localparam int BAR_BOTTOM = ARENA_TOP - BORDER - 1;

  int hc;
  int vc;
  logic in_bar;
  vga_pkg::rgb_t rgb_q;

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hp <= HP_FULL;
    end else if (!play_on) begin
      hp <= HP_FULL;
    end else if (damage && (hp != '0)) begin
      hp <= hp - 1'b1;
    end
  end

  assign game_over = play_on && (hp == '0);

  always_comb begin
    hc = int'(in.timing.hcount);
    vc = int'(in.timing.vcount);
    in_bar = (vc >= BAR_TOP) && (vc <= BAR_BOTTOM) &&
             (hc >= ARENA_LEFT) && (hc < ARENA_LEFT + int'(hp) * game_pkg::HP_BAR_UNIT) &&
             !in.timing.hblnk && !in.timing.vblnk;
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      rgb_q <= '0;
    end else begin
      rgb_q <= in_bar ? game_pkg::COLOR_HP : in.rgb;
    end
  end

  signal_delay #(.T(vga_pkg::vga_timing_t), .DEPTH(1)) timing_delay (
    .pclk  (pclk),
    .rst_n (rst_n),
    .din   (in.timing),
    .dout  (out.timing)
  );

  assign out.rgb = rgb_q;

endmodule

//--- hdl/game_video_top.sv
`timescale 1ns/1ps

module game_video_top #(
  parameter int H_ACTIVE     = vga_pkg::XGA_H_ACTIVE,
  parameter int H_FP         = vga_pkg::XGA_H_FP,
  parameter int H_SYNC       = vga_pkg::XGA_H_SYNC,
  parameter int H_BP         = vga_pkg::XGA_H_BP,
  parameter int V_ACTIVE     = vga_pkg::XGA_V_ACTIVE,
  parameter int V_FP         = vga_pkg::XGA_V_FP,
  parameter int V_SYNC       = vga_pkg::XGA_V_SYNC,
  parameter int V_BP         = vga_pkg::XGA_V_BP,
  parameter int ARENA_TOP    = game_pkg::DEF_ARENA_TOP,
  parameter int ARENA_BOTTOM = game_pkg::DEF_ARENA_BOTTOM,
  parameter int ARENA_LEFT   = game_pkg::DEF_ARENA_LEFT,
  parameter int ARENA_RIGHT  = game_pkg::DEF_ARENA_RIGHT,
  parameter int BORDER       = game_pkg::DEF_BORDER,
  parameter int HP_MAX       = game_pkg::DEF_HP_MAX
) (
  input  logic            pclk,
  input  logic            rst_n,
  input  logic            game_button,
  input  logic            menu_button,
  input  vga_pkg::coord_t cursor_x,
  input  vga_pkg::coord_t cursor_y,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output logic            hsync,
  output logic            vsync,
  output vga_pkg::rgb_t   rgb,
  output vga_pkg::coord_t obstacle_x,
  output vga_pkg::coord_t obstacle_y,
  output game_pkg::hp_t   hp,
  output logic            game_over
);

  vga_if raw ();
  vga_if arena_px ();
  vga_if obstacle_px ();
  vga_if hp_px ();

  game_pkg::pos_t cursor;
  game_pkg::pos_t obstacle;
  logic           play_on;
  logic           damage;
  logic           frame_start;

  assign cursor.x = cursor_x;
  assign cursor.y = cursor_y;

  // first pixel of a frame leaving the obstacle stage
  assign frame_start = (obstacle_px.timing.hcount == '0) && (obstacle_px.timing.vcount == '0);

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) u_vga_timing (
    .pclk  (pclk),
    .rst_n (rst_n),
    .out   (raw)
  );

  arena_draw #(
    .ARENA_TOP(ARENA_TOP), .ARENA_BOTTOM(ARENA_BOTTOM),
    .ARENA_LEFT(ARENA_LEFT), .ARENA_RIGHT(ARENA_RIGHT), .BORDER(BORDER)
  ) u_arena_draw (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .game_button (game_button),
    .menu_button (menu_button),
    .game_over   (game_over),
    .in          (raw),
    .out         (arena_px),
    .play_on     (play_on)
  );

  obstacle_layer #(
    .ARENA_TOP(ARENA_TOP), .ARENA_LEFT(ARENA_LEFT),
    .ARENA_RIGHT(ARENA_RIGHT), .BORDER(BORDER)
  ) u_obstacle_layer (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .play_on  (play_on),
    .in       (arena_px),
    .out      (obstacle_px),
    .obstacle (obstacle)
  );

  collision_detector u_collision_detector (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .cursor      (cursor),
    .obstacle    (obstacle),
    .frame_start (frame_start),
    .damage      (damage)
  );

  hp_overlay #(
    .ARENA_TOP(ARENA_TOP), .ARENA_LEFT(ARENA_LEFT), .BORDER(BORDER), .HP_MAX(HP_MAX)
  ) u_hp_overlay (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .play_on   (play_on),
    .damage    (damage),
    .in        (obstacle_px),
    .out       (hp_px),
    .hp        (hp),
    .game_over (game_over)
  );

  assign hcount     = hp_px.timing.hcount;
  assign vcount     = hp_px.timing.vcount;
  assign hsync      = hp_px.timing.hsync;
  assign vsync      = hp_px.timing.vsync;
  assign rgb        = hp_px.rgb;
  assign obstacle_x = obstacle.x;
  assign obstacle_y = obstacle.y;

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

// free-running pixel clock, 10 ns period
module tb_clock #(
  parameter int HALF_PERIOD = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

//--- test/game_video_tb.sv
`timescale 1ns/1ps

module game_video_tb;

  // small raster so that many frames fit in a short run
  localparam int H_ACTIVE = 64;
  localparam int H_FP = 4;
  localparam int H_SYNC = 8;
  localparam int H_BP = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FP = 2;
  localparam int V_SYNC = 3;
  localparam int V_BP = 3;
  localparam int ARENA_TOP = 12;
  localparam int ARENA_BOTTOM = 40;
  localparam int ARENA_LEFT = 12;
  localparam int ARENA_RIGHT = 31;
  localparam int BORDER = 3;
  localparam int HP_MAX = 8;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int HOME_X = ARENA_LEFT + BORDER;
  localparam int HOME_Y = ARENA_TOP + BORDER;
  localparam int BAR_TOP = ARENA_TOP - BORDER - 4;
  localparam int BAR_BOTTOM = ARENA_TOP - BORDER - 1;
  localparam int OBS_W = game_pkg::OBSTACLE_W;
  localparam int OBS_H = game_pkg::OBSTACLE_H;
  localparam int NUM_FRAMES = 36;
  localparam int WATCHDOG_NS = 40 * H_TOTAL * V_TOTAL * 10 + 2000;

  logic clk;
  logic rst_n;
  logic game_button;
  logic menu_button;
  vga_pkg::coord_t cursor_x;
  vga_pkg::coord_t cursor_y;
  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;
  logic hsync;
  logic vsync;
  vga_pkg::rgb_t rgb;
  vga_pkg::coord_t obstacle_x;
  vga_pkg::coord_t obstacle_y;
  game_pkg::hp_t hp;
  logic game_over;

  logic [15:0] lfsr;
  int exp_h;
  int exp_v;
  int m_ox;
  int m_hp;
  logic m_play;
  logic m_left;
  logic m_go;
  int go_count;
  int frames;
  int hits;
  int game_overs;
  int mismatches;
  int errors;
  logic pend_game;
  logic pend_menu;
  int pend_cx;
  int pend_cy;
  vga_pkg::rgb_t exp_rgb;
  logic exp_hsync;
  logic exp_vsync;

  tb_clock clock_gen (.clk(clk));

  game_video_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .ARENA_TOP(ARENA_TOP), .ARENA_BOTTOM(ARENA_BOTTOM),
    .ARENA_LEFT(ARENA_LEFT), .ARENA_RIGHT(ARENA_RIGHT),
    .BORDER(BORDER), .HP_MAX(HP_MAX)
  ) dut (
    .pclk(clk), .rst_n(rst_n),
    .game_button(game_button), .menu_button(menu_button),
    .cursor_x(cursor_x), .cursor_y(cursor_y),
    .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync), .rgb(rgb),
    .obstacle_x(obstacle_x), .obstacle_y(obstacle_y),
    .hp(hp), .game_over(game_over)
  );

  // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // health bar in front, then obstacle, arena, border and background
  function automatic vga_pkg::rgb_t expected_colour(input int h, input int v,
                                                     input int ox, input int hp_now);
    if (h >= H_ACTIVE || v >= V_ACTIVE)
      return '0;
    if (v >= BAR_TOP && v <= BAR_BOTTOM && h >= ARENA_LEFT &&
        h < ARENA_LEFT + hp_now * game_pkg::HP_BAR_UNIT)
      return game_pkg::COLOR_HP;
    if (h >= ox && h < ox + OBS_W && v >= HOME_Y && v < HOME_Y + OBS_H)
      return game_pkg::COLOR_OBSTACLE;
    if (h >= ARENA_LEFT && h <= ARENA_RIGHT && v >= ARENA_TOP && v <= ARENA_BOTTOM)
      return game_pkg::COLOR_ARENA;
    if (h >= ARENA_LEFT - BORDER && h <= ARENA_RIGHT + BORDER &&
        v >= ARENA_TOP - BORDER && v <= ARENA_BOTTOM + BORDER)
      return game_pkg::COLOR_BORDER;
    return game_pkg::COLOR_BG;
  endfunction

  // one frame of motion with a turn at the inner walls
  task automatic step_obstacle(inout int x, inout logic left, input logic play);
    if (!play) begin
      x = HOME_X;
      left = 1'b0;
    end else if (left) begin
      x = x - 1;
      if (x <= ARENA_LEFT)
        left = 1'b0;
    end else begin
      x = x + 1;
      if (x + OBS_W - 1 >= ARENA_RIGHT)
        left = 1'b1;
    end
  endtask

  task automatic start_frame();
    int cx;
    int cy;
    cx = int'(cursor_x);
    cy = int'(cursor_y);
    if (go_count != 0) begin
      $display("game_over was high late in frame %0d", frames);
      errors++;
    end
    go_count = 0;
    frames++;
    step_obstacle(m_ox, m_left, m_play);
    m_go = 1'b0;
    if (m_play && cx >= m_ox && cx <= m_ox + OBS_W - 1 &&
        cy >= HOME_Y && cy <= HOME_Y + OBS_H - 1) begin
      hits++;
      m_hp = m_hp - 1;
      if (m_hp == 0) begin
        m_go = 1'b1;
        m_play = 1'b0;
        m_hp = HP_MAX;
        game_overs++;
      end
    end
  endtask

  task automatic check_frame();
    if (int'(obstacle_x) != m_ox) begin
      $display("Mismatch obstacle_x: got %h expected %h", obstacle_x, m_ox[11:0]);
      mismatches++;
    end
    if (int'(obstacle_y) != HOME_Y) begin
      $display("Mismatch obstacle_y: got %h expected %h", obstacle_y, HOME_Y[11:0]);
      mismatches++;
    end
    if (int'(hp) != m_hp) begin
      $display("Mismatch hp: got %h expected %h", hp, m_hp[3:0]);
      mismatches++;
    end
    if (go_count != int'(m_go)) begin
      $display("game_over pulsed %0d times in frame %0d, expected %0d",
               go_count, frames, int'(m_go));
      errors++;
    end
    go_count = 0;
  endtask

  // buttons and cursor for the next frame are chosen during vertical blanking
  task automatic plan_frame();
    int sel;
    int near;
    int dx;
    int dy;
    int px;
    logic pl;
    take_bits(5, sel);
    pend_menu = (sel == 0) || (sel == 31);
    pend_game = (sel >= 1 && sel <= 6) || (sel == 31);
    if (pend_menu) begin
      m_play = 1'b0;
      m_hp = HP_MAX;
    end else if (pend_game) begin
      m_play = 1'b1;
    end
    px = m_ox;
    pl = m_left;
    step_obstacle(px, pl, m_play);
    take_bits(1, near);
    if (near == 1) begin
      take_bits(3, dx);
      take_bits(3, dy);
      pend_cx = px + dx % OBS_W;
      pend_cy = HOME_Y + dy % OBS_H;
    end else begin
      take_bits(6, pend_cx);
      take_bits(6, pend_cy);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d of %0d frames", frames, NUM_FRAMES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    game_button = 1'b0;
    menu_button = 1'b0;
    cursor_x = '0;
    cursor_y = '0;
    lfsr = 16'd90;
    frames = 0;
    hits = 0;
    game_overs = 0;
    mismatches = 0;
    errors = 0;
    go_count = 0;
    pend_cx = 0;
    pend_cy = 0;
    pend_game = 1'b0;
    pend_menu = 1'b0;
    m_play = 1'b0;
    m_left = 1'b0;
    m_go = 1'b0;
    m_ox = HOME_X;
    m_hp = HP_MAX;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (game_over !== 1'b0) begin
      $display("Mismatch game_over: got %h expected 0", game_over);
      mismatches++;
    end
    if (int'(hp) != HP_MAX) begin
      $display("Mismatch hp: got %h expected %h", hp, HP_MAX[3:0]);
      mismatches++;
    end
    if (int'(obstacle_x) != HOME_X) begin
      $display("Mismatch obstacle_x: got %h expected %h", obstacle_x, HOME_X[11:0]);
      mismatches++;
    end
    if (int'(obstacle_y) != HOME_Y) begin
      $display("Mismatch obstacle_y: got %h expected %h", obstacle_y, HOME_Y[11:0]);
      mismatches++;
    end
    if (rgb !== '0) begin
      $display("Mismatch rgb: got %h expected 000", rgb);
      mismatches++;
    end
    // first real pixel after the pipeline fills
    while (!(hcount == 12'd1 && vcount == 12'd0))
      @(negedge clk);
    exp_h = 1;
    exp_v = 0;
    while (frames < NUM_FRAMES) begin
      exp_h = exp_h + 1;
      if (exp_h == H_TOTAL) begin
        exp_h = 0;
        exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
      end
      @(posedge clk);
      #1;
      game_button = pend_game;
      menu_button = pend_menu;
      cursor_x = vga_pkg::coord_t'(pend_cx);
      cursor_y = vga_pkg::coord_t'(pend_cy);
      pend_game = 1'b0;
      pend_menu = 1'b0;
      @(negedge clk);
      if (exp_h == 0 && exp_v == 0)
        start_frame();
      if (int'(hcount) != exp_h || int'(vcount) != exp_v) begin
        $display("Mismatch hcount/vcount: got %h/%h expected %h/%h",
                 hcount, vcount, exp_h[11:0], exp_v[11:0]);
        mismatches++;
      end
      exp_hsync = (exp_h >= H_ACTIVE + H_FP && exp_h < H_ACTIVE + H_FP + H_SYNC);
      exp_vsync = (exp_v >= V_ACTIVE + V_FP && exp_v < V_ACTIVE + V_FP + V_SYNC);
      if (hsync !== exp_hsync) begin
        $display("Mismatch hsync at hcount %h: got %h expected %h",
                 exp_h[11:0], hsync, exp_hsync);
        mismatches++;
      end
      if (vsync !== exp_vsync) begin
        $display("Mismatch vsync at vcount %h: got %h expected %h",
                 exp_v[11:0], vsync, exp_vsync);
        mismatches++;
      end
      exp_rgb = expected_colour(exp_h, exp_v, m_ox, m_hp);
      if (rgb !== exp_rgb) begin
        $display("Mismatch rgb at (%h,%h): got %h expected %h",
                 exp_h[11:0], exp_v[11:0], rgb, exp_rgb);
        mismatches++;
      end
      if (game_over === 1'b1)
        go_count++;
      if (exp_h == 0 && exp_v == 1)
        check_frame();
      if (exp_h == 0 && exp_v == V_ACTIVE)
        plan_frame();
    end
    $display("%0d mismatches, %0d other errors, %0d frames, %0d hits, %0d game overs",
             mismatches, errors, frames, hits, game_overs);
    if (mismatches == 0 && errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- game_video_top.f
common/vga_pkg.sv
common/game_pkg.sv
common/vga_if.sv
hdl/vga_timing.sv
hdl/signal_delay.sv
arena/arena_draw.sv
arena/obstacle_layer.sv
hdl/collision_detector.sv
hdl/hp_overlay.sv
hdl/game_video_top.sv
test/tb_clock.sv
test/game_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module game_video_tb \
  -f game_video_top.f -o game_video_sim || exit 1
result=$(./obj_dir/game_video_sim)
echo "$result"
echo "$result" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
